/* logic/ssb_demod_pkg.sv */
package ssb_demod_pkg;

    localparam int IQ_W     = 16;
    localparam int SAMPLE_W = 2 * IQ_W;

    localparam int DEFAULT_NFFT = 8;        // log2 of fft length

    // cp length field, longest cp is 20 samples
    localparam int CP_LEN_W = 5;

    // 14 symbols per slot, 20 slots between ssb bursts
    localparam int SYMS_PER_SSB_PERIOD = 14 * 20;
    localparam int SYM_CNT_W           = $clog2(SYMS_PER_SSB_PERIOD);

    typedef struct packed {
        logic [IQ_W-1:0] im;
        logic [IQ_W-1:0] re;
    } iq_sample_t;

    // time domain input beat
    typedef struct packed {
        iq_sample_t          sample;
        logic [CP_LEN_W-1:0] cp_len;    // cp of the symbol this beat belongs to
        logic                last;      // final beat of the symbol period
        logic                valid;
    } td_sample_t;

    // symbol body, cp already stripped
    typedef struct packed {
        iq_sample_t sample;
        logic       valid;
        logic       sym_last;
    } sym_sample_t;

    // bins in shifted order, dc in the middle
    typedef struct packed {
        iq_sample_t sample;
        logic       valid;
        logic       bin_first;
        logic       bin_last;
    } fd_sample_t;

endpackage

/* logic/cp_remover.sv */
`timescale 1ns/1ps

module cp_remover #(
    parameter int NFFT = ssb_demod_pkg::DEFAULT_NFFT
) (
    input  logic                      clk_i,
    input  logic                      reset_ni,
    input  ssb_demod_pkg::td_sample_t td_i,
    output ssb_demod_pkg::sym_sample_t sym_o
);

    import ssb_demod_pkg::*;

    typedef enum logic [1:0] {
        S_SKIP_CP,
        S_BODY,
        S_SKIP_TAIL
    } state_t;

    state_t              state;
    logic [CP_LEN_W-1:0] cp_cnt;
    logic [NFFT-1:0]     body_cnt;

    wire body_beat = td_i.valid && (state == S_BODY);
    wire body_end  = body_beat && (&body_cnt);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state    <= S_SKIP_CP;
            cp_cnt   <= '0;
            body_cnt <= '0;
        end else begin
            case (state)
                S_SKIP_CP: begin
                    body_cnt <= '0;
                    if (td_i.valid) begin
                        // cp length comes with the beat itself
                        if (cp_cnt == td_i.cp_len - 1'b1) begin
                            cp_cnt <= '0;
                            state  <= S_BODY;
                        end else begin
                            cp_cnt <= cp_cnt + 1'b1;
                        end
                    end
                end
                S_BODY: begin
                    if (td_i.valid) begin
                        body_cnt <= body_cnt + 1'b1;     // wraps to 0 on the last body beat
                        if (body_end) begin
                            state <= td_i.last ? S_SKIP_CP : S_SKIP_TAIL;
                        end
                    end
                end
                S_SKIP_TAIL: begin
                    // drop the trailing samples up to the end of the period
                    if (td_i.valid && td_i.last) begin
                        state <= S_SKIP_CP;
                    end
                end
                default: begin
                    state <= S_SKIP_CP;
                end
            endcase
        end
    end

    // one cycle from input beat to body sample
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            sym_o.valid    <= 1'b0;
            sym_o.sym_last <= 1'b0;
        end else begin
            sym_o.valid    <= body_beat;
            sym_o.sym_last <= body_end;
            sym_o.sample   <= td_i.sample;
        end
    end

    a_cp_len_nonzero : assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        td_i.valid |-> (td_i.cp_len != '0)
    ) else $error("cp_remover: zero cp length on a valid beat");

endmodule

/* logic/shift_symbol_buffer.sv */
`timescale 1ns/1ps

module shift_symbol_buffer #(
    parameter int NFFT = ssb_demod_pkg::DEFAULT_NFFT
) (
    input  logic                       clk_i,
    input  logic                       reset_ni,
    input  ssb_demod_pkg::sym_sample_t sym_i,
    output ssb_demod_pkg::fd_sample_t  fd_o
);

    import ssb_demod_pkg::*;

    localparam int LEN = 1 << NFFT;

    // two banks back to back, bank select is the address msb
    logic [SAMPLE_W-1:0] mem [2*LEN];

    logic            wr_bank;
    logic [NFFT-1:0] wr_idx;
    logic [1:0]      bank_full;     // bank holds a complete symbol not yet played
    logic            rd_bank;
    logic [NFFT-1:0] rd_cnt;

    wire sym_done = sym_i.valid && sym_i.sym_last;
    wire rd_go    = bank_full[rd_bank];
    wire rd_end   = rd_go && (&rd_cnt);

    // inverting the index msb moves the upper half to the front
    wire [NFFT-1:0] rd_idx = {~rd_cnt[NFFT-1], rd_cnt[NFFT-2:0]};

    always_ff @(posedge clk_i) begin
        if (sym_i.valid) begin
            mem[{wr_bank, wr_idx}] <= sym_i.sample;
        end
        if (rd_go) begin
            fd_o.sample <= mem[{rd_bank, rd_idx}];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_bank <= 1'b0;
            wr_idx  <= '0;
        end else if (sym_i.valid) begin
            wr_idx <= sym_done ? '0 : wr_idx + 1'b1;
            if (sym_done) begin
                wr_bank <= ~wr_bank;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            bank_full <= '0;
            rd_bank   <= 1'b0;
            rd_cnt    <= '0;
        end else begin
            if (rd_go) begin
                rd_cnt <= rd_cnt + 1'b1;
                if (rd_end) begin
                    bank_full[rd_bank] <= 1'b0;
                    rd_bank            <= ~rd_bank;
                end
            end
            // setting after clearing, only an overrun hits the same bank
            if (sym_done) begin
                bank_full[wr_bank] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            fd_o.valid     <= 1'b0;
            fd_o.bin_first <= 1'b0;
            fd_o.bin_last  <= 1'b0;
        end else begin
            fd_o.valid     <= rd_go;
            fd_o.bin_first <= rd_go && (rd_cnt == '0);
            fd_o.bin_last  <= rd_end;
        end
    end

    a_no_overrun : assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        sym_i.valid |-> !bank_full[wr_bank]
    ) else $error("shift_symbol_buffer: write into a bank not yet played");

    a_symbol_contiguous : assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        (fd_o.valid && !fd_o.bin_last) |=> fd_o.valid
    ) else $error("shift_symbol_buffer: gap inside an output symbol");

endmodule

/* logic/ssb_subcarrier_tagger.sv */
`timescale 1ns/1ps

module ssb_subcarrier_tagger #(
    parameter int NFFT = ssb_demod_pkg::DEFAULT_NFFT
) (
    input  logic                      clk_i,
    input  logic                      reset_ni,
    input  ssb_demod_pkg::fd_sample_t fd_i,
    input  logic                      ssb_start_i,
    output ssb_demod_pkg::iq_sample_t m_data_o,
    output logic                      m_valid_o,
    output logic                      m_last_o,
    output logic                      m_pbch_sym_o,
    output logic                      pbch_valid_o,
    output logic                      sss_valid_o
);

    import ssb_demod_pkg::*;

    localparam int LEN = 1 << NFFT;

    // 256 point values 8, 240, 64 and 127 scaled to the fft length
    localparam logic [NFFT-1:0] USED_START = NFFT'(LEN / 32);
    localparam logic [NFFT-1:0] USED_CNT   = NFFT'(LEN * 15 / 16);
    localparam logic [NFFT-1:0] USED_LAST  = USED_START + USED_CNT - 1'b1;
    localparam logic [NFFT-1:0] SSS_START  = NFFT'(LEN / 4);
    localparam logic [NFFT-1:0] SSS_CNT    = NFFT'(LEN / 2 - 1);

    logic [NFFT-1:0]      bin_cnt;
    logic [SYM_CNT_W-1:0] sym_cnt;
    logic                 ssb_pend;     // realign request seen mid symbol

    wire [NFFT-1:0] bin_idx  = fd_i.bin_first ? '0 : bin_cnt;
    wire [NFFT-1:0] used_off = bin_idx - USED_START;   // bins below start wrap past the count
    wire [NFFT-1:0] sss_off  = bin_idx - SSS_START;
    wire            in_used  = used_off < USED_CNT;
    wire            in_sss   = sss_off < SSS_CNT;
    wire            sym_end  = fd_i.valid && fd_i.bin_last;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            bin_cnt  <= '0;
            sym_cnt  <= '0;
            ssb_pend <= 1'b0;
        end else begin
            if (fd_i.valid) begin
                bin_cnt <= bin_idx + 1'b1;
            end
            if (sym_end) begin
                ssb_pend <= 1'b0;
                if (ssb_pend || ssb_start_i || sym_cnt == SYMS_PER_SSB_PERIOD - 1) begin
                    sym_cnt <= '0;
                end else begin
                    sym_cnt <= sym_cnt + 1'b1;
                end
            end else if (ssb_start_i) begin
                if (fd_i.valid) ssb_pend <= 1'b1;   // finish this symbol first
                else sym_cnt <= '0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            m_valid_o    <= 1'b0;
            m_last_o     <= 1'b0;
            m_pbch_sym_o <= 1'b0;
            pbch_valid_o <= 1'b0;
            sss_valid_o  <= 1'b0;
        end else begin
            m_valid_o    <= fd_i.valid && in_used;
            m_last_o     <= fd_i.valid && (bin_idx == USED_LAST);
            pbch_valid_o <= fd_i.valid && in_used && (sym_cnt == 0);
            sss_valid_o  <= fd_i.valid && in_sss && (sym_cnt == 1);
            if (fd_i.valid) begin
                m_pbch_sym_o <= (sym_cnt == 0);     // level, qualified by m_valid_o
            end
        end
    end

    always_ff @(posedge clk_i) begin
        m_data_o <= fd_i.sample;
    end

    a_sss_in_window : assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        sss_valid_o |-> m_valid_o
    ) else $error("ssb_subcarrier_tagger: sss bin outside the used window");

endmodule

/* logic/ssb_demod_top.sv */
`timescale 1ns/1ps

module ssb_demod_top #(
    parameter int NFFT = ssb_demod_pkg::DEFAULT_NFFT
) (
    input  logic                      clk_i,
    input  logic                      reset_ni,
    input  ssb_demod_pkg::td_sample_t td_i,
    input  logic                      ssb_start_i,
    output ssb_demod_pkg::iq_sample_t m_data_o,
    output logic                      m_valid_o,
    output logic                      m_last_o,
    output logic                      m_pbch_sym_o,
    output logic                      pbch_valid_o,
    output logic                      sss_valid_o
);

    import ssb_demod_pkg::*;

    sym_sample_t sym_s;     // body samples, cp removed
    fd_sample_t  fd_s;      // shifted bin order

    cp_remover #(
        .NFFT(NFFT)
    ) u_cp_remover (
        .clk_i   (clk_i),
        .reset_ni(reset_ni),
        .td_i    (td_i),
        .sym_o   (sym_s)
    );

    // stands where the fft core goes
    shift_symbol_buffer #(
        .NFFT(NFFT)
    ) u_shift_symbol_buffer (
        .clk_i   (clk_i),
        .reset_ni(reset_ni),
        .sym_i   (sym_s),
        .fd_o    (fd_s)
    );

    ssb_subcarrier_tagger #(
        .NFFT(NFFT)
    ) u_ssb_subcarrier_tagger (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .fd_i        (fd_s),
        .ssb_start_i (ssb_start_i),
        .m_data_o    (m_data_o),
        .m_valid_o   (m_valid_o),
        .m_last_o    (m_last_o),
        .m_pbch_sym_o(m_pbch_sym_o),
        .pbch_valid_o(pbch_valid_o),
        .sss_valid_o (sss_valid_o)
    );

endmodule

/* sim/ssb_demod_checker.sv */
`timescale 1ns/1ps

module ssb_demod_checker #(
    parameter int NFFT = 4
) (
    input  logic                               clk_i,
    input  logic                               reset_ni,
    input  logic                               desc_valid_i,
    input  logic [ssb_demod_pkg::CP_LEN_W-1:0] desc_cp_i,
    input  logic [ssb_demod_pkg::IQ_W-1:0]     desc_sym_i,
    input  logic                               desc_ssb_i,
    input  ssb_demod_pkg::iq_sample_t          m_data_i,
    input  logic                               m_valid_i,
    input  logic                               m_last_i,
    input  logic                               m_pbch_sym_i,
    input  logic                               pbch_valid_i,
    input  logic                               sss_valid_i,
    output int                                 error_cnt_o,
    output int                                 sym_done_o
);

    import ssb_demod_pkg::*;

    localparam int LEN        = 1 << NFFT;
    // 256 point window bounds scaled to the fft length
    localparam int USED_FIRST = LEN / 32;
    localparam int USED_LAST  = USED_FIRST + LEN * 15 / 16 - 1;
    localparam int SSS_FIRST  = LEN / 4;
    localparam int SSS_LAST   = SSS_FIRST + LEN / 2 - 2;

    int   exp_cp_q[$];      // one entry per symbol with a complete body
    int   exp_sym_q[$];
    int   exp_idx_q[$];
    int   last_idx = SYMS_PER_SSB_PERIOD - 1;     // first symbol after reset lands on 0
    int   errors   = 0;
    int   done     = 0;
    logic in_sym   = 1'b0;
    logic orphan   = 1'b0;
    int   bin;
    int   cur_cp;
    int   cur_sym;
    int   cur_idx;

    assign error_cnt_o = errors;
    assign sym_done_o  = done;

    task automatic compare_value(input string name, input int got, input int expected);
        if (got != expected) begin
            $display("Mismatch at %0d ns: %s expected %0d, got %0d", $time, name, expected, got);
            errors++;
        end
    endtask

    always @(posedge clk_i) begin
        if (reset_ni && desc_valid_i) begin
            last_idx = desc_ssb_i ? 0 : (last_idx + 1) % SYMS_PER_SSB_PERIOD;
            exp_cp_q.push_back(int'(desc_cp_i));
            exp_sym_q.push_back(int'(desc_sym_i));
            exp_idx_q.push_back(last_idx);
        end
    end

    always @(negedge clk_i) begin
        if (!reset_ni) begin
            compare_value("m_valid_o", int'(m_valid_i), 0);
            compare_value("m_last_o", int'(m_last_i), 0);
            compare_value("pbch_valid_o", int'(pbch_valid_i), 0);
            compare_value("sss_valid_o", int'(sss_valid_i), 0);
        end else if (m_valid_i) begin
            if (!in_sym) begin
                in_sym = 1'b1;
                bin    = USED_FIRST;
                orphan = (exp_cp_q.size() == 0);
                if (orphan) begin
                    $display("Error at %0d ns: output symbol started before its body was sent",
                             $time);
                    errors++;
                end else begin
                    cur_cp  = exp_cp_q.pop_front();
                    cur_sym = exp_sym_q.pop_front();
                    cur_idx = exp_idx_q.pop_front();
                end
            end
            if (!orphan) begin
                // bin k holds body sample k + len/2, and re counts from the cp start
                compare_value("m_data_o.re", int'(m_data_i.re), cur_cp + (bin + LEN / 2) % LEN);
                compare_value("m_data_o.im", int'(m_data_i.im), cur_sym);
                compare_value("m_last_o", int'(m_last_i), int'(bin == USED_LAST));
                compare_value("m_pbch_sym_o", int'(m_pbch_sym_i), int'(cur_idx == 0));
                compare_value("pbch_valid_o", int'(pbch_valid_i), int'(cur_idx == 0));
                compare_value("sss_valid_o", int'(sss_valid_i),
                              int'(cur_idx == 1 && bin >= SSS_FIRST && bin <= SSS_LAST));
            end
            if (bin == USED_LAST) begin
                in_sym = 1'b0;
                if (!orphan) done++;
            end else begin
                bin++;
            end
        end else begin
            if (in_sym) begin
                $display("Error at %0d ns: output symbol stopped after %0d of %0d used bins",
                         $time, bin - USED_FIRST, USED_LAST - USED_FIRST + 1);
                errors++;
                in_sym = 1'b0;
            end
            compare_value("m_last_o", int'(m_last_i), 0);
            compare_value("pbch_valid_o", int'(pbch_valid_i), 0);
            compare_value("sss_valid_o", int'(sss_valid_i), 0);
        end
    end

endmodule

/* sim/tb_ssb_demod.sv */
`timescale 1ns/1ps

module tb_ssb_demod #(
    parameter int NFFT = 4,
    parameter int SEED = 79
);

    import ssb_demod_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int LEN        = 1 << NFFT;
    localparam int MAX_TESTS  = 32;
    localparam int DESC_W     = 5;      // words per line of the data file

    logic                clk_i = 1'b0;
    logic                reset_ni;
    td_sample_t          td;
    logic                ssb_start;
    iq_sample_t          m_data;
    logic                m_valid;
    logic                m_last;
    logic                m_pbch_sym;
    logic                pbch_valid;
    logic                sss_valid;
    logic                desc_valid;
    logic [CP_LEN_W-1:0] desc_cp;
    logic [IQ_W-1:0]     desc_sym;
    logic                desc_ssb;
    int                  error_cnt;
    int                  sym_done;

    logic [15:0] desc_mem [MAX_TESTS*DESC_W];
    int          timeout_cycles = 0;
    int          sym_num        = 0;    // running symbol number, carried in im

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    ssb_demod_top #(
        .NFFT(NFFT)
    ) uut (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .td_i        (td),
        .ssb_start_i (ssb_start),
        .m_data_o    (m_data),
        .m_valid_o   (m_valid),
        .m_last_o    (m_last),
        .m_pbch_sym_o(m_pbch_sym),
        .pbch_valid_o(pbch_valid),
        .sss_valid_o (sss_valid)
    );

    ssb_demod_checker #(
        .NFFT(NFFT)
    ) u_checker (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .desc_valid_i(desc_valid),
        .desc_cp_i   (desc_cp),
        .desc_sym_i  (desc_sym),
        .desc_ssb_i  (desc_ssb),
        .m_data_i    (m_data),
        .m_valid_i   (m_valid),
        .m_last_i    (m_last),
        .m_pbch_sym_i(m_pbch_sym),
        .pbch_valid_i(pbch_valid),
        .sss_valid_i (sss_valid),
        .error_cnt_o (error_cnt),
        .sym_done_o  (sym_done)
    );

    task automatic drive_idle();
        @(negedge clk_i);
        td.valid   = 1'b0;
        td.last    = 1'b0;
        desc_valid = 1'b0;
    endtask

    task automatic pulse_ssb_start();
        @(negedge clk_i);
        ssb_start = 1'b1;
        @(negedge clk_i);
        ssb_start = 1'b0;
    endtask

    // cp, body and tail of one symbol period, re is the position in the period
    task automatic send_symbol(input int cp, input int tail, input int gap, input logic ssb);
        int period;
        int pos;
        int idle;
        period = cp + LEN + tail;
        for (pos = 0; pos < period; pos++) begin
            idle = $urandom % (gap + 1);
            repeat (idle) drive_idle();
            @(negedge clk_i);
            td.valid     = 1'b1;
            td.last      = (pos == period - 1);
            td.cp_len    = CP_LEN_W'(cp);
            td.sample.re = IQ_W'(pos);
            td.sample.im = IQ_W'(sym_num);
            desc_valid   = (pos == cp + LEN - 1);   // told with the final body beat
            desc_cp      = CP_LEN_W'(cp);
            desc_sym     = IQ_W'(sym_num);
            desc_ssb     = ssb;
        end
        sym_num++;
    endtask

    // the checker counts on the falling edge, so look on the rising one
    task automatic wait_drained(input int target);
        while (sym_done != target) @(posedge clk_i);
    endtask

    initial begin
        int n_tests;
        int limit;
        int t;
        int r;
        int cp;
        int tail;
        int gap;
        int reps;
        int ssb;
        int sym_sent;
        int err_before;
        int errs;
        int passed;
        int failed;
        n_tests  = 0;
        sym_sent = 0;
        passed   = 0;
        failed   = 0;
        void'($urandom(SEED));
        td         = '0;
        ssb_start  = 1'b0;
        desc_valid = 1'b0;
        desc_cp    = '0;
        desc_sym   = '0;
        desc_ssb   = 1'b0;
        reset_ni   = 1'b0;
        $readmemh("sim/symbols_input.txt", desc_mem);
        limit = 2 * LEN + 100;
        while (n_tests < MAX_TESTS && desc_mem[n_tests * DESC_W] != '0) begin
            cp   = int'(desc_mem[n_tests * DESC_W]);
            tail = int'(desc_mem[n_tests * DESC_W + 1]);
            gap  = int'(desc_mem[n_tests * DESC_W + 2]);
            reps = int'(desc_mem[n_tests * DESC_W + 3]);
            limit += reps * (cp + LEN + tail) * (gap + 1) + 3 * LEN + 10;
            n_tests++;
        end
        timeout_cycles = limit;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        reset_ni = 1'b1;

        for (t = 0; t < n_tests; t++) begin
            cp         = int'(desc_mem[t * DESC_W]);
            tail       = int'(desc_mem[t * DESC_W + 1]);
            gap        = int'(desc_mem[t * DESC_W + 2]);
            reps       = int'(desc_mem[t * DESC_W + 3]);
            ssb        = int'(desc_mem[t * DESC_W + 4]);
            err_before = error_cnt;
            // pipeline is empty here, so the next symbol is the first of the period
            if (ssb != 0) pulse_ssb_start();
            for (r = 0; r < reps; r++) begin
                send_symbol(cp, tail, gap, (ssb != 0) && (r == 0));
                sym_sent++;
            end
            drive_idle();
            wait_drained(sym_sent);
            errs = error_cnt - err_before;
            if (errs == 0) passed++;
            else failed++;
            $display("test %0d: cp %0d, tail %0d, gap up to %0d, %0d symbols, %0d errors, %s",
                     t + 1, cp, tail, gap, reps, errs, (errs == 0) ? "pass" : "fail");
        end

        repeat (2 * LEN) @(negedge clk_i);     // catch stray output bins
        if (n_tests == 0) $display("no test lines found in sim/symbols_input.txt");
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 n_tests, passed, failed, error_cnt);
        if (n_tests != 0 && failed == 0 && error_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        wait (timeout_cycles != 0);
        #(timeout_cycles * CLK_PERIOD);
        $display("timeout after %0d cycles, the output symbols did not all arrive",
                 timeout_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* flist.f */
logic/ssb_demod_pkg.sv
logic/cp_remover.sv
logic/shift_symbol_buffer.sv
logic/ssb_subcarrier_tagger.sv
logic/ssb_demod_top.sv
sim/ssb_demod_checker.sv
sim/tb_ssb_demod.sv

/* Makefile */
TOP       ?= tb_ssb_demod
LINT_TOP  ?= ssb_demod_top
SIM_NFFT  ?= 4
SEED      ?= 79
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
FLIST     ?= flist.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

PARAMS    := -GNFFT=$(SIM_NFFT) -GSEED=$(SEED)
PASS_MSG  := *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) $(PARAMS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

# the run fails unless the pass line shows up in the simulator output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

lint:
	$(VERILATOR) --lint-only -Wall --timing -GNFFT=$(SIM_NFFT) \
		--top-module $(LINT_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

/* sim/symbols_input.txt */
// one test per line, hex words: cp_len tail_samples max_idle_gap repeat_count ssb_start
// a line of zeros ends the list
04 00 0 0002 1  // plain cp removal, pbch then sss symbol
01 00 0 0003 0  // shortest cp, back to back
14 00 0 0002 0  // longest cp
05 03 0 0003 0  // trailing samples after the body
02 07 2 0002 1  // realign mid period, tail and gaps
09 00 3 0004 0  // idle gaps between beats
03 01 0 0118 1  // one full ssb period
06 00 1 0002 0  // wraps back to the pbch symbol
07 02 0 0003 1
0b 05 4 0002 0
00 00 0 0000 0
